//--- design/boot_rom_image.svh
// ----------------------------------------------------------
// boot ROM contents as a constant word table, included
// inside a module body by the ROM and the testbench model
// ----------------------------------------------------------

`ifndef BOOT_ROM_IMAGE_SVH
`define BOOT_ROM_IMAGE_SVH

// two words per line, lowest address first
localparam soc_pkg::data_t RomImage [soc_pkg::RomWords] = '{
  64'h0000_0517_f140_25f3, 64'h0205_0513_0000_0297,
  64'h8000_02b7_0182_8293, 64'h0002_8067_1050_0073,
  64'h0200_0337_0003_2383, 64'hffdf_f06f_0010_0413,
  64'h4000_04b7_0084_a023, 64'h0014_0413_0ff4_7413,
  64'h0084_a023_fe5f_f06f, 64'h0000_0013_0000_0013,
  64'hedfe_0dd0_0000_1000, 64'h3800_0000_4800_0000,
  64'h1100_0000_2800_0000, 64'h1000_0000_0000_0000,
  64'h6c00_0000_0000_0000, 64'h0100_0000_0000_0000,
  64'h0300_0000_0400_0000, 64'h0000_0000_0200_0000,
  64'h7663_7369_725f_7a6e, 64'h6563_6976_6564_0000,
  64'h0100_0000_7570_6300, 64'h0300_0000_0400_0000,
  64'h0000_0000_00fa_f080, 64'h6d65_6d6f_7279_4080,
  64'h0000_0080_0000_0000, 64'h0000_2000_0000_0000,
  64'h636c_696e_7440_3230, 64'h3030_3030_3000_0000,
  64'h6770_696f_4034_3030, 64'h3030_3030_3000_0000,
  64'h0200_0000_0900_0000, 64'h5a5a_a5a5_c3c3_3c3c
};

`endif

//--- design/soc_pkg.sv
// ----------------------------------------------------------
// shared definitions for the memory-mapped system: widths,
// address map, CLINT and GPIO register offsets, bus structs
// imported by every RTL block and by the testbench
// ----------------------------------------------------------

package soc_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // ----------------------------------------------------------
  // address map
  // ----------------------------------------------------------
  localparam int unsigned NrSlaves = 4;

  typedef enum logic [1:0] {
    SlvRom   = 2'd0,
    SlvClint = 2'd1,
    SlvGpio  = 2'd2,
    SlvRam   = 2'd3
  } slave_e;

  localparam addr_t RomBase     = 32'h0001_0000;
  localparam addr_t RomLength   = 32'h0000_1000;
  localparam int unsigned RomWords = 32;

  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0000_C000;

  localparam addr_t GpioBase    = 32'h4000_0000;
  localparam addr_t GpioLength  = 32'h0000_1000;

  localparam addr_t RamBase     = 32'h8000_0000;
  localparam addr_t RamLength   = 32'h0000_2000;
  localparam int unsigned RamWords = 1024;

  // region table, one entry per slave_e value
  localparam addr_t RegionStart [NrSlaves] = '{RomBase, ClintBase, GpioBase, RamBase};
  localparam addr_t RegionEnd   [NrSlaves] = '{
    RomBase   + RomLength   - 1,
    ClintBase + ClintLength - 1,
    GpioBase  + GpioLength  - 1,
    RamBase   + RamLength   - 1
  };

  // register offsets within a region
  localparam addr_t MsipOffset     = 32'h0000_0000;
  localparam addr_t MtimecmpOffset = 32'h0000_4000;
  localparam addr_t MtimeOffset    = 32'h0000_BFF8;
  localparam addr_t LedOffset      = 32'h0000_0000;
  localparam addr_t SwOffset       = 32'h0000_0008;

  // ----------------------------------------------------------
  // bus payloads
  // ----------------------------------------------------------
  typedef struct packed {
    logic  we;
    addr_t addr;
    strb_t be;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

endpackage

//--- design/bus_demux.sv
// ----------------------------------------------------------
// address-region decoder: strobes the matching target and
// returns its read data one cycle after the request
// ----------------------------------------------------------

`timescale 1ns/1ns

module bus_demux (
  input  logic                        clk,
  input  logic                        ndmreset_n,
  input  logic                        req_valid_i,
  input  soc_pkg::bus_req_t           bus_req_i,
  output logic [soc_pkg::NrSlaves-1:0] slave_req_o,
  input  soc_pkg::data_t              slave_rdata_i [soc_pkg::NrSlaves],
  output logic                        rsp_valid_o,
  output soc_pkg::bus_rsp_t           bus_rsp_o
);

  import soc_pkg::*;

  logic [NrSlaves-1:0] hit;
  slave_e              sel;
  logic                miss;

  logic                rsp_valid_q;
  slave_e              sel_q;
  logic                err_q;
  logic                rd_q;

  // ----------------------------------------------------------
  // region match
  // ----------------------------------------------------------
  always_comb begin
    hit = '0;
    sel = SlvRom;
    for (int unsigned i = 0; i < NrSlaves; i++) begin
      if (bus_req_i.addr >= RegionStart[i] && bus_req_i.addr <= RegionEnd[i]) begin
        hit[i] = 1'b1;
        sel    = slave_e'(i);
      end
    end
  end

  assign miss        = ~|hit;
  assign slave_req_o = hit & {NrSlaves{req_valid_i}};

  // ----------------------------------------------------------
  // response tracking
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_q <= 1'b0;
      sel_q       <= SlvRom;
      err_q       <= 1'b0;
      rd_q        <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
      sel_q       <= sel;
      // unmapped access reports an error, touches nothing
      err_q       <= req_valid_i & miss;
      rd_q        <= req_valid_i & ~miss & ~bus_req_i.we;
    end
  end

  assign rsp_valid_o     = rsp_valid_q;
  // writes and errors give zero data
  assign bus_rsp_o.rdata = rd_q ? slave_rdata_i[sel_q] : '0;
  assign bus_rsp_o.err   = err_q;

endmodule

//--- design/boot_rom.sv
// ----------------------------------------------------------
// boot ROM: constant word table with a registered read port,
// write strobes are treated as reads and their data dropped
// ----------------------------------------------------------

`timescale 1ns/1ns

module boot_rom (
  input  logic           clk,
  input  logic           req_i,
  input  soc_pkg::addr_t addr_i,
  output soc_pkg::data_t rdata_o
);

  import soc_pkg::*;

  `include "boot_rom_image.svh"

  data_t rdata_q;

  // 64-bit word select
  always_ff @(posedge clk) begin
    if (req_i) begin
      rdata_q <= RomImage[addr_i[7:3]];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- design/sram.sv
// ----------------------------------------------------------
// RAM in place of DRAM: word memory with byte-enable writes
// and a registered read, one cycle from strobe to data
// ----------------------------------------------------------

`timescale 1ns/1ns

module sram (
  input  logic              clk,
  input  logic              req_i,
  input  soc_pkg::bus_req_t bus_req_i,
  output soc_pkg::data_t    rdata_o
);

  import soc_pkg::*;

  data_t                       mem [RamWords];
  data_t                       rdata_q;
  logic [$clog2(RamWords)-1:0] word_idx;

  assign word_idx = bus_req_i.addr[12:3];

  // byte lanes written under their enables
  always_ff @(posedge clk) begin
    for (int b = 0; b < StrbWidth; b++) begin
      if (req_i && bus_req_i.we && bus_req_i.be[b]) begin
        mem[word_idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
      end
    end
  end

  // read port
  always_ff @(posedge clk) begin
    if (req_i && !bus_req_i.we) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- design/clint.sv
// ----------------------------------------------------------
// core-local interruptor for one hart: rtc tick at half the
// clock, mtime, mtimecmp and msip, timer and software irqs
// ----------------------------------------------------------

`timescale 1ns/1ns

module clint (
  input  logic              clk,
  input  logic              ndmreset_n,
  input  logic              req_i,
  input  soc_pkg::bus_req_t bus_req_i,
  output soc_pkg::data_t    rdata_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  import soc_pkg::*;

  logic        rtc_q;
  logic        rtc_tick;
  data_t       mtime_q;
  data_t       mtimecmp_q;
  logic        msip_q;
  logic        timer_irq_q;
  data_t       rdata_q;
  logic [15:3] word_off;
  logic        wr_en;
  logic        rd_en;

  function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t be);
    data_t res;
    res = old_val;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign word_off = bus_req_i.addr[15:3];
  assign wr_en    = req_i & bus_req_i.we;
  assign rd_en    = req_i & ~bus_req_i.we;
  // rtc is high for one clk after each rising edge, every second clk
  assign rtc_tick = rtc_q;

  // ----------------------------------------------------------
  // timer and interrupt registers
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q       <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
    end else begin
      rtc_q <= ~rtc_q;
      // a bus write wins over the tick
      if (wr_en && word_off == MtimeOffset[15:3]) begin
        mtime_q <= merge_bytes(mtime_q, bus_req_i.wdata, bus_req_i.be);
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && word_off == MtimecmpOffset[15:3]) begin
        mtimecmp_q <= merge_bytes(mtimecmp_q, bus_req_i.wdata, bus_req_i.be);
      end
      if (wr_en && word_off == MsipOffset[15:3] && bus_req_i.be[0]) begin
        msip_q <= bus_req_i.wdata[0];
      end
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // register readback
  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (word_off == MtimeOffset[15:3]) begin
        rdata_q <= mtime_q;
      end else if (word_off == MtimecmpOffset[15:3]) begin
        rdata_q <= mtimecmp_q;
      end else if (word_off == MsipOffset[15:3]) begin
        rdata_q <= {{(DataWidth-1){1'b0}}, msip_q};
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

endmodule

//--- design/gpio.sv
// ----------------------------------------------------------
// GPIO: LED byte register and two-stage synchronizer on the
// DIP switch inputs, both readable over the bus
// ----------------------------------------------------------

`timescale 1ns/1ns

module gpio (
  input  logic              clk,
  input  logic              ndmreset_n,
  input  logic              req_i,
  input  soc_pkg::bus_req_t bus_req_i,
  input  logic [7:0]        sw_i,
  output soc_pkg::data_t    rdata_o,
  output logic [7:0]        led_o
);

  import soc_pkg::*;

  logic [7:0]  led_q;
  logic [7:0]  sw_meta_q;
  logic [7:0]  sw_sync_q;
  logic [11:3] word_off;
  data_t       rdata_q;

  assign word_off = bus_req_i.addr[11:3];

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      led_q     <= '0;
      sw_meta_q <= '0;
      sw_sync_q <= '0;
    end else begin
      sw_meta_q <= sw_i;
      sw_sync_q <= sw_meta_q;
      if (req_i && bus_req_i.we && bus_req_i.be[0] && word_off == LedOffset[11:3]) begin
        led_q <= bus_req_i.wdata[7:0];
      end
    end
  end

  // zero-extended readback
  always_ff @(posedge clk) begin
    if (req_i && !bus_req_i.we) begin
      if (word_off == LedOffset[11:3]) begin
        rdata_q <= {{(DataWidth-8){1'b0}}, led_q};
      end else if (word_off == SwOffset[11:3]) begin
        rdata_q <= {{(DataWidth-8){1'b0}}, sw_sync_q};
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o = rdata_q;
  assign led_o   = led_q;

endmodule

//--- design/soc_top.sv
// ----------------------------------------------------------
// top level of the memory-mapped system: one external bus
// master reaches boot ROM, CLINT, GPIO and RAM through the
// address decoder
// ----------------------------------------------------------

`timescale 1ns/1ns

module soc_top (
  input  logic              clk,
  input  logic              ndmreset_n,
  input  logic              req_valid_i,
  input  soc_pkg::bus_req_t bus_req_i,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t bus_rsp_o,
  input  logic [7:0]        sw_i,
  output logic [7:0]        led_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  import soc_pkg::*;

  logic [NrSlaves-1:0] slave_req;
  data_t               slave_rdata [NrSlaves];

  // ----------------------------------------------------------
  // address decoder
  // ----------------------------------------------------------
  bus_demux i_bus_demux (
    .clk           ( clk         ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_valid_i   ( req_valid_i ),
    .bus_req_i     ( bus_req_i   ),
    .slave_req_o   ( slave_req   ),
    .slave_rdata_i ( slave_rdata ),
    .rsp_valid_o   ( rsp_valid_o ),
    .bus_rsp_o     ( bus_rsp_o   )
  );

  // ----------------------------------------------------------
  // targets
  // ----------------------------------------------------------
  boot_rom i_boot_rom (
    .clk     ( clk                 ),
    .req_i   ( slave_req[SlvRom]   ),
    .addr_i  ( bus_req_i.addr      ),
    .rdata_o ( slave_rdata[SlvRom] )
  );

  sram i_sram (
    .clk       ( clk                 ),
    .req_i     ( slave_req[SlvRam]   ),
    .bus_req_i ( bus_req_i           ),
    .rdata_o   ( slave_rdata[SlvRam] )
  );

  clint i_clint (
    .clk         ( clk                   ),
    .ndmreset_n  ( ndmreset_n            ),
    .req_i       ( slave_req[SlvClint]   ),
    .bus_req_i   ( bus_req_i             ),
    .rdata_o     ( slave_rdata[SlvClint] ),
    .timer_irq_o ( timer_irq_o           ),
    .ipi_o       ( ipi_o                 )
  );

  gpio i_gpio (
    .clk        ( clk                  ),
    .ndmreset_n ( ndmreset_n           ),
    .req_i      ( slave_req[SlvGpio]   ),
    .bus_req_i  ( bus_req_i            ),
    .sw_i       ( sw_i                 ),
    .rdata_o    ( slave_rdata[SlvGpio] ),
    .led_o      ( led_o                )
  );

endmodule

//--- bench/tb_soc_top.sv
// ----------------------------------------------------------
// testbench for soc_top: seeded random bus traffic checked
// against a model of the ROM, RAM, GPIO and CLINT
// ----------------------------------------------------------

`timescale 1ns/1ns

module tb_soc_top;

  import soc_pkg::*;

  // guard was already set when the ROM was compiled
  `undef BOOT_ROM_IMAGE_SVH
  `include "boot_rom_image.svh"

  typedef struct packed {
    bus_rsp_t rsp;
    logic     bounded;
    data_t    lo;
    data_t    hi;
  } exp_t;

  logic       clk;
  logic       ndmreset_n;
  logic       req_valid_i;
  bus_req_t   bus_req_i;
  logic       rsp_valid_o;
  bus_rsp_t   bus_rsp_o;
  logic [7:0] sw_i;
  logic [7:0] led_o;
  logic       timer_irq_o;
  logic       ipi_o;

  // model state
  data_t      ram_model [RamWords];
  logic [7:0] led_model;
  exp_t       exp_q [$];
  logic       pending;
  bus_rsp_t   last_rsp;
  int         cycle;
  int         checks;
  int         mismatches;
  int         timeouts;

  soc_top dut_i (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_valid_i ( req_valid_i ),
    .bus_req_i   ( bus_req_i   ),
    .rsp_valid_o ( rsp_valid_o ),
    .bus_rsp_o   ( bus_rsp_o   ),
    .sw_i        ( sw_i        ),
    .led_o       ( led_o       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------
  task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got rdata=%h err=%b, expected rdata=%h err=%b",
               $time, name, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_rsp_range(input string name, input bus_rsp_t got,
                                 input data_t lo, input data_t hi);
    checks++;
    if (got.err !== 1'b0 || ((got.rdata >= lo) && (got.rdata <= hi)) !== 1'b1) begin
      mismatches++;
      $display("Mismatch at %0t: %s got rdata=%h err=%b, expected rdata in %h..%h err=0",
               $time, name, got.rdata, got.err, lo, hi);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // model helpers
  // ----------------------------------------------------------
  function automatic data_t merge_lanes(input data_t old_val, input data_t new_val,
                                        input strb_t be);
    data_t res;
    res = old_val;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic exp_t exact(input data_t rdata, input logic err);
    exp_t e;
    e = '0;
    e.rsp.rdata = rdata;
    e.rsp.err = err;
    return e;
  endfunction

  function automatic bus_req_t make_req(input logic we, input addr_t addr, input strb_t be,
                                        input data_t wdata);
    bus_req_t r;
    r.we = we;
    r.addr = addr;
    r.be = be;
    r.wdata = wdata;
    return r;
  endfunction

  function automatic logic mapped(input addr_t a);
    return (a >= RomBase && a < RomBase + RomLength) ||
           (a >= ClintBase && a < ClintBase + ClintLength) ||
           (a >= GpioBase && a < GpioBase + GpioLength) ||
           (a >= RamBase && a < RamBase + RamLength);
  endfunction

  // random address outside every region, low bits on one RAM word
  function automatic addr_t unmapped_addr(input int idx);
    addr_t a;
    a = addr_t'($urandom);
    a[12:3] = idx[9:0];
    for (int n = 0; n < 64 && mapped(a); n++) begin
      a = addr_t'($urandom);
      a[12:3] = idx[9:0];
    end
    return a;
  endfunction

  // sixteen RAM words spread over the array
  function automatic int ram_pick(input int k);
    return (k * 67 + 5) % RamWords;
  endfunction

  function automatic addr_t ram_addr(input int idx);
    return RamBase + (addr_t'(idx) << 3);
  endfunction

  // ----------------------------------------------------------
  // bus driver, one call per clock cycle
  // ----------------------------------------------------------
  task automatic collect_response();
    exp_t e;
    check_bit("rsp_valid_o", rsp_valid_o, pending);
    last_rsp = bus_rsp_o;
    if (pending) begin
      e = exp_q.pop_front();
      if (e.bounded) begin
        check_rsp_range("bus_rsp_o", bus_rsp_o, e.lo, e.hi);
      end else begin
        check_rsp("bus_rsp_o", bus_rsp_o, e.rsp);
      end
    end
  endtask

  task automatic step(input logic valid, input bus_req_t req, input exp_t e);
    @(negedge clk);
    collect_response();
    req_valid_i = valid;
    bus_req_i   = req;
    pending     = valid;
    if (valid) begin
      exp_q.push_back(e);
    end
    cycle++;
  endtask

  task automatic idle();
    step(1'b0, '0, '0);
  endtask

  task automatic bus_write(input addr_t addr, input strb_t be, input data_t wdata);
    step(1'b1, make_req(1'b1, addr, be, wdata), exact('0, 1'b0));
  endtask

  task automatic bus_read(input addr_t addr, input data_t exp_data);
    step(1'b1, make_req(1'b0, addr, '0, '0), exact(exp_data, 1'b0));
  endtask

  task automatic bus_read_range(input addr_t addr, input data_t lo, input data_t hi);
    exp_t e;
    e = exact('0, 1'b0);
    e.bounded = 1'b1;
    e.lo = lo;
    e.hi = hi;
    step(1'b1, make_req(1'b0, addr, '0, '0), e);
  endtask

  task automatic ram_write(input int idx, input strb_t be, input data_t wdata);
    ram_model[idx] = merge_lanes(ram_model[idx], wdata, be);
    bus_write(ram_addr(idx), be, wdata);
  endtask

  // which selects timer_irq_o (0) or ipi_o (1)
  task automatic wait_level(input string name, input int which, input logic level,
                            input int limit);
    int   n;
    logic cur;
    n = 0;
    cur = (which == 0) ? timer_irq_o : ipi_o;
    while (n < limit && cur !== level) begin
      idle();
      cur = (which == 0) ? timer_irq_o : ipi_o;
      n++;
    end
    if (cur !== level) begin
      timeouts++;
      $display("Timeout at %0t: %s did not reach %b within %0d cycles", $time, name, level, limit);
    end
    check_bit(name, cur, level);
  endtask

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------
  initial begin : stimulus
    addr_t      a;
    data_t      v;
    data_t      m;
    logic [7:0] sw_val;
    int         idx;
    int         cw;
    int         gap;
    void'($urandom(31));
    ndmreset_n  = 1'b0;
    req_valid_i = 1'b0;
    bus_req_i   = '0;
    sw_i        = '0;
    pending     = 1'b0;
    led_model   = '0;
    cycle       = 0;
    checks      = 0;
    mismatches  = 0;
    timeouts    = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    ndmreset_n = 1'b1;
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_byte("led_o", led_o, 8'h00);
    check_bit("timer_irq_o", timer_irq_o, 1'b0);
    check_bit("ipi_o", ipi_o, 1'b0);

    // boot ROM reads, then a write that must not stick
    for (int k = 0; k < 20; k++) begin
      a = RomBase + ((addr_t'($urandom) % RomLength) & ~addr_t'(7));
      bus_read(a, RomImage[a[7:3]]);
    end
    bus_write(a, '1, {$urandom, $urandom});
    bus_read(a, RomImage[a[7:3]]);

    // RAM fill, then back-to-back mixed traffic
    for (int k = 0; k < 16; k++) begin
      idx = ram_pick(k);
      ram_write(idx, '1, {ram_addr(idx), ~ram_addr(idx)});
    end
    for (int k = 0; k < 80; k++) begin
      idx = ram_pick(int'($urandom % 16));
      if ($urandom % 2 == 1) begin
        ram_write(idx, strb_t'($urandom), {$urandom, $urandom});
      end else begin
        bus_read(ram_addr(idx), ram_model[idx]);
      end
    end

    // unmapped accesses aimed at one RAM word, which must stay intact
    idx = ram_pick(3);
    for (int k = 0; k < 8; k++) begin
      a = unmapped_addr(idx);
      step(1'b1, make_req(k[0], a, '1, {$urandom, $urandom}), exact('0, 1'b1));
    end
    bus_read(ram_addr(idx), ram_model[idx]);

    // GPIO LEDs and switches
    v = {$urandom, $urandom};
    led_model = v[7:0];
    bus_write(GpioBase + LedOffset, 8'h01, v);
    idle();
    check_byte("led_o", led_o, led_model);
    bus_write(GpioBase + LedOffset, 8'hfe, ~v);
    idle();
    check_byte("led_o", led_o, led_model);
    bus_read(GpioBase + LedOffset, {56'b0, led_model});
    sw_val = 8'($urandom);
    sw_i = sw_val;
    repeat (3) idle();
    bus_read(GpioBase + SwOffset, {56'b0, sw_val});

    // CLINT software interrupt
    bus_write(ClintBase + MsipOffset, 8'h01, 64'h1);
    wait_level("ipi_o", 1, 1'b1, 4);
    bus_read(ClintBase + MsipOffset, 64'h1);
    bus_write(ClintBase + MsipOffset, 8'h01, 64'h0);
    wait_level("ipi_o", 1, 1'b0, 4);

    // mtime runs at half the clock rate
    v = {1'b0, 31'($urandom), $urandom};
    bus_write(ClintBase + MtimeOffset, '1, v);
    cw = cycle;
    gap = 2 + int'($urandom % 20);
    repeat (gap) idle();
    bus_read_range(ClintBase + MtimeOffset, v,
                   v + data_t'((cycle + 1 - cw) / 2) + 64'd1);
    idle();
    m = last_rsp.rdata;

    // timer interrupt
    bus_write(ClintBase + MtimecmpOffset, '1, m + 64'd4);
    wait_level("timer_irq_o", 0, 1'b1, 40);
    bus_write(ClintBase + MtimecmpOffset, '1, '1);
    wait_level("timer_irq_o", 0, 1'b0, 6);
    bus_read(ClintBase + MtimecmpOffset, '1);
    idle();
    idle();

    $display("checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+design
design/soc_pkg.sv
design/bus_demux.sv
design/boot_rom.sv
design/sram.sv
design/clint.sv
design/gpio.sv
design/soc_top.sv
bench/tb_soc_top.sv

//--- Makefile
# Verilator build and run of the memory-mapped system testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary -j 0

SOURCES := $(wildcard design/*.sv design/*.svh bench/*.sv)
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || [ $$status -ne 0 ]; then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
